/* hw/ooo_pkg.sv */
package ooo_pkg;

	localparam int SS_SIZE      = 2;
	localparam int ROB_SIZE     = 8;
	localparam int ROB_IDX_W    = $clog2(ROB_SIZE);
	localparam int NUM_PHYS_REG = 32;
	localparam int PHYS_W       = $clog2(NUM_PHYS_REG);
	localparam int EXEC_LAT     = 3;

	localparam logic [5:0] OP_NOP  = 6'h00;
	localparam logic [5:0] OP_ALU  = 6'h01;
	localparam logic [5:0] OP_BR   = 6'h02;
	localparam logic [5:0] OP_HALT = 6'h3f;

	localparam logic [1:0] BR_NEVER  = 2'b00;
	localparam logic [1:0] BR_ALWAYS = 2'b01;

	typedef logic [PHYS_W-1:0] phys_reg_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  dest;
		logic [4:0]  src_a;
		logic [4:0]  src_b;
		logic [10:0] func;
	} alu_instr_t;

	typedef struct packed {
		logic [5:0]  opcode;   // Same bits as the alu view
		logic [1:0]  cond;
		logic [23:0] disp;     // In words
	} br_instr_t;

	typedef union packed {
		alu_instr_t alu;
		br_instr_t  branch;
	} instr_u;

	typedef struct packed {
		logic        busy;
		logic        ready;
		phys_reg_t   t_new;
		phys_reg_t   t_old;
		logic [4:0]  wr_idx;
		logic        halt;
		logic        is_br;
		logic        mispredict;
		logic [31:0] npc;
		logic [31:0] target;
	} rob_row_t;

endpackage

/* hw/dispatch_decode.sv */
module dispatch_decode (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        inst_valid [ooo_pkg::SS_SIZE],
	input  ooo_pkg::instr_u             inst_word [ooo_pkg::SS_SIZE],
	input  logic [ooo_pkg::ROB_IDX_W:0] free_rows,
	output logic                        dispatch_en [ooo_pkg::SS_SIZE],
	output logic [4:0]                  wr_idx [ooo_pkg::SS_SIZE],
	output logic                        halt [ooo_pkg::SS_SIZE],
	output logic                        is_br [ooo_pkg::SS_SIZE],
	output logic [1:0]                  cond [ooo_pkg::SS_SIZE],
	output logic [23:0]                 disp [ooo_pkg::SS_SIZE]
);
	import ooo_pkg::*;

	logic       live [SS_SIZE];
	logic [5:0] opcode [SS_SIZE];

	// Field extraction per lane
	always_comb begin
		for (int j = 0; j < SS_SIZE; j++) begin
			opcode[j] = inst_word[j].alu.opcode;
			live[j]   = inst_valid[j] && (opcode[j] != OP_NOP);
			halt[j]   = (opcode[j] == OP_HALT);
			is_br[j]  = (opcode[j] == OP_BR);

			// Only ALU ops name a destination
			if (opcode[j] == OP_ALU) begin
				wr_idx[j] = inst_word[j].alu.dest;
			end else begin
				wr_idx[j] = 5'd0;
			end

			cond[j] = inst_word[j].branch.cond;   // Don't care unless is_br
			disp[j] = inst_word[j].branch.disp;
		end
	end

	// Lanes fill in order as room allows
	always_comb begin
		dispatch_en[0] = live[0] && (free_rows >= 1);
		if (live[0]) begin
			dispatch_en[1] = live[1] && dispatch_en[0] && (free_rows >= 2);
		end else begin
			dispatch_en[1] = live[1] && (free_rows >= 1);   // Lane 1 takes the single row
		end
	end

endmodule

/* hw/exec_pipe.sv */
module exec_pipe (
	input  logic               clock,
	input  logic               rst,
	input  logic               flush,
	input  logic               dispatch_en [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t t_new_in [ooo_pkg::SS_SIZE],
	input  logic               is_br [ooo_pkg::SS_SIZE],
	input  logic [1:0]         cond [ooo_pkg::SS_SIZE],
	input  logic [23:0]        disp [ooo_pkg::SS_SIZE],
	input  logic [31:0]        npc [ooo_pkg::SS_SIZE],
	output logic               cdb_en [ooo_pkg::SS_SIZE],
	output ooo_pkg::phys_reg_t cdb_tag [ooo_pkg::SS_SIZE],
	output logic               cdb_br_mispred [ooo_pkg::SS_SIZE],
	output logic [31:0]        cdb_br_target [ooo_pkg::SS_SIZE]
);
	import ooo_pkg::*;

	logic [SS_SIZE-1:0] st_en [EXEC_LAT];
	logic [SS_SIZE-1:0] st_mispred [EXEC_LAT];
	phys_reg_t          st_tag [EXEC_LAT][SS_SIZE];
	logic [31:0]        st_target [EXEC_LAT][SS_SIZE];
	logic               mispred_in [SS_SIZE];
	logic [31:0]        target_in [SS_SIZE];

	// Branch resolution at entry; prediction is always not taken
	always_comb begin
		for (int j = 0; j < SS_SIZE; j++) begin
			case (cond[j])
				BR_ALWAYS: mispred_in[j] = is_br[j];
				BR_NEVER:  mispred_in[j] = 1'b0;
				default:   mispred_in[j] = 1'b0;
			endcase
			target_in[j] = npc[j] + {{6{disp[j][23]}}, disp[j], 2'b00};
		end
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			for (int k = 0; k < EXEC_LAT; k++) st_en[k] <= '0;
		end else begin
			for (int j = 0; j < SS_SIZE; j++) st_en[0][j] <= dispatch_en[j];
			for (int k = 1; k < EXEC_LAT; k++) st_en[k] <= st_en[k-1];
		end
	end

	// Tag and branch result move one stage per cycle
	always_ff @(posedge clock) begin
		for (int j = 0; j < SS_SIZE; j++) begin
			st_tag[0][j]     <= t_new_in[j];
			st_mispred[0][j] <= mispred_in[j];
			st_target[0][j]  <= target_in[j];
		end
		for (int k = 1; k < EXEC_LAT; k++) begin
			st_tag[k]     <= st_tag[k-1];
			st_mispred[k] <= st_mispred[k-1];
			st_target[k]  <= st_target[k-1];
		end
	end

	always_comb begin
		for (int j = 0; j < SS_SIZE; j++) begin
			cdb_en[j]         = st_en[EXEC_LAT-1][j];
			cdb_tag[j]        = st_tag[EXEC_LAT-1][j];
			cdb_br_mispred[j] = st_mispred[EXEC_LAT-1][j];
			cdb_br_target[j]  = st_target[EXEC_LAT-1][j];
		end
	end

endmodule

/* hw/rob_tag_cam.sv */
module rob_tag_cam (
	input  logic                         cam_en [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t           tags [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t           table_tags [ooo_pkg::ROB_SIZE],
	output logic [ooo_pkg::SS_SIZE-1:0]  hits [ooo_pkg::ROB_SIZE]
);
	import ooo_pkg::*;

	// One comparator per row and CDB lane
	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) begin
			for (int j = 0; j < SS_SIZE; j++) begin
				hits[i][j] = cam_en[j] && (table_tags[i] == tags[j]);
			end
		end
	end

endmodule

/* hw/rob.sv */
module rob (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        flush,
	input  logic                        halted,
	input  logic                        dispatch_en [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t          t_new_in [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t          t_old_in [ooo_pkg::SS_SIZE],
	input  logic [4:0]                  wr_idx [ooo_pkg::SS_SIZE],
	input  logic                        halt [ooo_pkg::SS_SIZE],
	input  logic                        is_br [ooo_pkg::SS_SIZE],
	input  logic [31:0]                 npc [ooo_pkg::SS_SIZE],
	input  logic                        cdb_en [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t          cdb_tag [ooo_pkg::SS_SIZE],
	input  logic                        cdb_br_mispred [ooo_pkg::SS_SIZE],
	input  logic [31:0]                 cdb_br_target [ooo_pkg::SS_SIZE],
	output logic                        retire_valid [ooo_pkg::SS_SIZE],
	output ooo_pkg::rob_row_t           retire_row [ooo_pkg::SS_SIZE],
	output logic [ooo_pkg::ROB_IDX_W:0] free_rows,
	output logic                        full
);
	import ooo_pkg::*;

	rob_row_t             rows [ROB_SIZE];
	rob_row_t             rows_next [ROB_SIZE];
	logic [ROB_IDX_W-1:0] head;
	logic [ROB_IDX_W-1:0] tail;
	logic [ROB_IDX_W-1:0] head_1;
	logic [ROB_IDX_W-1:0] slot [SS_SIZE];
	logic [ROB_IDX_W:0]   n_disp;
	logic [ROB_IDX_W:0]   n_ret;
	logic [ROB_IDX_W:0]   free_next;
	logic                 head_stop;
	phys_reg_t            row_tags [ROB_SIZE];
	logic [SS_SIZE-1:0]   hits [ROB_SIZE];

	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) row_tags[i] = rows[i].t_new;
	end

	rob_tag_cam u_cam (
		.cam_en     (cdb_en),
		.tags       (cdb_tag),
		.table_tags (row_tags),
		.hits       (hits)
	);

	// Second row retires only behind a plain first row
	assign head_1    = head + ROB_IDX_W'(1);
	assign head_stop = rows[head].halt || (rows[head].is_br && rows[head].mispredict);

	assign retire_valid[0] = !flush && !halted && rows[head].busy && rows[head].ready;
	assign retire_valid[1] = retire_valid[0] && !head_stop
		&& rows[head_1].busy && rows[head_1].ready;
	assign retire_row[0] = rows[head];
	assign retire_row[1] = rows[head_1];

	always_comb begin
		rows_next = rows;

		// Completion from the CDB
		for (int i = 0; i < ROB_SIZE; i++) begin
			for (int j = 0; j < SS_SIZE; j++) begin
				if (rows[i].busy && hits[i][j]) begin
					rows_next[i].ready      = 1'b1;
					rows_next[i].mispredict = cdb_br_mispred[j];
					rows_next[i].target     = cdb_br_target[j];
				end
			end
		end

		if (retire_valid[0]) begin
			rows_next[head].busy  = 1'b0;
			rows_next[head].ready = 1'b0;
		end
		if (retire_valid[1]) begin
			rows_next[head_1].busy  = 1'b0;
			rows_next[head_1].ready = 1'b0;
		end
		n_ret = (ROB_IDX_W+1)'(retire_valid[0]) + (ROB_IDX_W+1)'(retire_valid[1]);

		// Lane 1 packs behind lane 0 when both go
		slot[0] = tail;
		slot[1] = tail + ROB_IDX_W'(dispatch_en[0]);
		n_disp  = '0;
		for (int j = 0; j < SS_SIZE; j++) begin
			if (dispatch_en[j]) begin
				rows_next[slot[j]].busy       = 1'b1;
				rows_next[slot[j]].ready      = halt[j] || (wr_idx[j] == 5'd0 && !is_br[j]);
				rows_next[slot[j]].t_new      = t_new_in[j];
				rows_next[slot[j]].t_old      = t_old_in[j];
				rows_next[slot[j]].wr_idx     = wr_idx[j];
				rows_next[slot[j]].halt       = halt[j];
				rows_next[slot[j]].is_br      = is_br[j];
				rows_next[slot[j]].mispredict = 1'b0;
				rows_next[slot[j]].npc        = npc[j];
				rows_next[slot[j]].target     = npc[j];   // Fall-through until resolved
				n_disp = n_disp + 1'b1;
			end
		end

		free_next = free_rows + n_ret - n_disp;
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			head      <= '0;
			tail      <= '0;
			free_rows <= (ROB_IDX_W+1)'(ROB_SIZE);
			full      <= 1'b0;
			for (int i = 0; i < ROB_SIZE; i++) begin
				rows[i].busy       <= 1'b0;
				rows[i].ready      <= 1'b0;
				rows[i].mispredict <= 1'b0;
			end
		end else begin
			rows      <= rows_next;
			head      <= head + n_ret[ROB_IDX_W-1:0];
			tail      <= tail + n_disp[ROB_IDX_W-1:0];
			free_rows <= free_next;
			full      <= (free_next == '0);
		end
	end

endmodule

/* hw/retire_unit.sv */
module retire_unit (
	input  logic               clock,
	input  logic               rst,
	input  logic               retire_valid [ooo_pkg::SS_SIZE],
	input  ooo_pkg::rob_row_t  retire_row [ooo_pkg::SS_SIZE],
	output logic               free_valid [ooo_pkg::SS_SIZE],
	output ooo_pkg::phys_reg_t free_tag [ooo_pkg::SS_SIZE],
	output logic [4:0]         free_wr_idx [ooo_pkg::SS_SIZE],
	output logic               halted,
	output logic               flush,
	output logic [31:0]        redirect_pc
);
	import ooo_pkg::*;

	logic        halt_hit;
	logic        br_flush_0;
	logic        br_flush_1;
	logic [31:0] flush_target;

	// A mispredicted branch is always the youngest row retired
	assign br_flush_0 = retire_valid[0] && retire_row[0].is_br && retire_row[0].mispredict;
	assign br_flush_1 = retire_valid[1] && retire_row[1].is_br && retire_row[1].mispredict;
	assign flush_target = br_flush_1 ? retire_row[1].target : retire_row[0].target;
	assign halt_hit = (retire_valid[0] && retire_row[0].halt)
		|| (retire_valid[1] && retire_row[1].halt);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int j = 0; j < SS_SIZE; j++) free_valid[j] <= 1'b0;
			halted <= 1'b0;
			flush  <= 1'b0;
		end else begin
			for (int j = 0; j < SS_SIZE; j++) free_valid[j] <= retire_valid[j];
			halted <= halted || halt_hit;   // Sticky until reset
			flush  <= br_flush_0 || br_flush_1;
		end
	end

	always_ff @(posedge clock) begin
		for (int j = 0; j < SS_SIZE; j++) begin
			free_tag[j]    <= retire_row[j].t_old;
			free_wr_idx[j] <= retire_row[j].wr_idx;
		end
		if (br_flush_0 || br_flush_1) redirect_pc <= flush_target;
	end

endmodule

/* hw/ooo_backend_top.sv */
module ooo_backend_top (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        inst_valid [ooo_pkg::SS_SIZE],
	input  ooo_pkg::instr_u             inst_word [ooo_pkg::SS_SIZE],
	input  logic [31:0]                 npc [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t          t_new_in [ooo_pkg::SS_SIZE],
	input  ooo_pkg::phys_reg_t          t_old_in [ooo_pkg::SS_SIZE],
	output logic                        free_valid [ooo_pkg::SS_SIZE],
	output ooo_pkg::phys_reg_t          free_tag [ooo_pkg::SS_SIZE],
	output logic [4:0]                  free_wr_idx [ooo_pkg::SS_SIZE],
	output logic                        halted,
	output logic                        flush,
	output logic [31:0]                 redirect_pc,
	output logic [ooo_pkg::ROB_IDX_W:0] free_rows,
	output logic                        full
);
	import ooo_pkg::*;

	logic        dispatch_en [SS_SIZE];
	logic [4:0]  wr_idx [SS_SIZE];
	logic        halt [SS_SIZE];
	logic        is_br [SS_SIZE];
	logic [1:0]  cond [SS_SIZE];
	logic [23:0] disp [SS_SIZE];
	logic        cdb_en [SS_SIZE];
	phys_reg_t   cdb_tag [SS_SIZE];
	logic        cdb_br_mispred [SS_SIZE];
	logic [31:0] cdb_br_target [SS_SIZE];
	logic        retire_valid [SS_SIZE];
	rob_row_t    retire_row [SS_SIZE];

	dispatch_decode u_decode (
		.clock       (clock),
		.rst         (rst),
		.inst_valid  (inst_valid),
		.inst_word   (inst_word),
		.free_rows   (free_rows),
		.dispatch_en (dispatch_en),
		.wr_idx      (wr_idx),
		.halt        (halt),
		.is_br       (is_br),
		.cond        (cond),
		.disp        (disp)
	);

	exec_pipe u_exec (
		.clock          (clock),
		.rst            (rst),
		.flush          (flush),
		.dispatch_en    (dispatch_en),
		.t_new_in       (t_new_in),
		.is_br          (is_br),
		.cond           (cond),
		.disp           (disp),
		.npc            (npc),
		.cdb_en         (cdb_en),
		.cdb_tag        (cdb_tag),
		.cdb_br_mispred (cdb_br_mispred),
		.cdb_br_target  (cdb_br_target)
	);

	rob u_rob (
		.clock          (clock),
		.rst            (rst),
		.flush          (flush),
		.halted         (halted),
		.dispatch_en    (dispatch_en),
		.t_new_in       (t_new_in),
		.t_old_in       (t_old_in),
		.wr_idx         (wr_idx),
		.halt           (halt),
		.is_br          (is_br),
		.npc            (npc),
		.cdb_en         (cdb_en),
		.cdb_tag        (cdb_tag),
		.cdb_br_mispred (cdb_br_mispred),
		.cdb_br_target  (cdb_br_target),
		.retire_valid   (retire_valid),
		.retire_row     (retire_row),
		.free_rows      (free_rows),
		.full           (full)
	);

	retire_unit u_retire (
		.clock        (clock),
		.rst          (rst),
		.retire_valid (retire_valid),
		.retire_row   (retire_row),
		.free_valid   (free_valid),
		.free_tag     (free_tag),
		.free_wr_idx  (free_wr_idx),
		.halted       (halted),
		.flush        (flush),
		.redirect_pc  (redirect_pc)
	);

endmodule

/* verif/ooo_backend_tb.sv */
module ooo_backend_tb;
	import ooo_pkg::*;

	logic               clock;
	logic               rst;
	logic               inst_valid [SS_SIZE];
	instr_u             inst_word [SS_SIZE];
	logic [31:0]        npc [SS_SIZE];
	phys_reg_t          t_new_in [SS_SIZE];
	phys_reg_t          t_old_in [SS_SIZE];
	logic               free_valid [SS_SIZE];
	phys_reg_t          free_tag [SS_SIZE];
	logic [4:0]         free_wr_idx [SS_SIZE];
	logic               halted;
	logic               flush;
	logic [31:0]        redirect_pc;
	logic [ROB_IDX_W:0] free_rows;
	logic               full;

	phys_reg_t   expect_q [$];   // Old tags still waiting in dispatch order
	logic [4:0]  idx_q [$];      // Their architectural indices
	int          mismatches;
	int          other_errors;
	int          flush_count;
	int          tag_ctr;
	logic [31:0] pc_base;
	logic        full_seen;

	ooo_backend_top DUT (.*);

	always #5 clock = ~clock;

	task automatic check_tag(input phys_reg_t got, input phys_reg_t exp, input string name);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_idx(input logic [4:0] got, input logic [4:0] exp, input string name);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input logic [ROB_IDX_W:0] got, input logic [ROB_IDX_W:0] exp,
			input string name);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic instr_u alu_word();
		instr_u w;
		w = '0;
		w.alu.opcode = OP_ALU;
		w.alu.dest   = 5'(1 + $urandom % 31);   // r0 would mean no destination
		return w;
	endfunction

	function automatic instr_u br_word(input logic [1:0] cond, input int disp);
		instr_u w;
		w.branch.opcode = OP_BR;
		w.branch.cond   = cond;
		w.branch.disp   = 24'(disp);
		return w;
	endfunction

	// Branches and halts write no register
	function automatic logic [4:0] arch_dest(input instr_u w);
		case (w.alu.opcode)
			OP_ALU:  return w.alu.dest;
			default: return 5'd0;
		endcase
	endfunction

	// One idle cycle that ends at the falling edge
	task automatic step();
		@(posedge clock);
		inst_valid[0] <= 1'b0;
		inst_valid[1] <= 1'b0;
		@(negedge clock);
	endtask

	task automatic apply_reset();
		@(posedge clock);
		rst           <= 1'b1;
		inst_valid[0] <= 1'b0;
		inst_valid[1] <= 1'b0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		@(negedge clock);
		expect_q.delete();
		idx_q.delete();
	endtask

	// Drives one pair; keep marks lanes whose old tag must come back
	task automatic issue_pair(input logic v0, input instr_u w0, input logic keep0,
			input logic v1, input instr_u w1, input logic keep1);
		phys_reg_t old_tag [SS_SIZE];
		logic      acc [SS_SIZE];
		int        fr;
		int        need1;
		for (int j = 0; j < SS_SIZE; j++) old_tag[j] = phys_reg_t'($urandom % NUM_PHYS_REG);
		@(posedge clock);
		inst_valid[0] <= v0;
		inst_valid[1] <= v1;
		inst_word[0]  <= w0;
		inst_word[1]  <= w1;
		for (int j = 0; j < SS_SIZE; j++) begin
			t_new_in[j] <= phys_reg_t'(tag_ctr % NUM_PHYS_REG);   // Unique among rows in flight
			t_old_in[j] <= old_tag[j];
			npc[j]      <= pc_base + 32'(4 * (j + 1));
			tag_ctr++;
		end
		pc_base += 32'd8;
		@(negedge clock);
		fr     = int'(free_rows);
		need1  = v0 ? 2 : 1;   // Lane 1 needs its own row behind lane 0
		acc[0] = v0 && (fr >= 1);
		acc[1] = v1 && (fr >= need1);
		if (full) full_seen = 1'b1;
		if (acc[0] && keep0) begin
			expect_q.push_back(old_tag[0]);
			idx_q.push_back(arch_dest(w0));
		end
		if (acc[1] && keep1) begin
			expect_q.push_back(old_tag[1]);
			idx_q.push_back(arch_dest(w1));
		end
	endtask

	task automatic drain(input int limit);
		for (int n = 0; n < limit && (expect_q.size() != 0 || int'(free_rows) != ROB_SIZE); n++)
			step();
		if (expect_q.size() != 0) begin
			other_errors++;
			$display("error at time %0t: %0d old tags were never freed", $time, expect_q.size());
		end
		check_count(free_rows, (ROB_IDX_W+1)'(ROB_SIZE), "free_rows");
	endtask

	// Freed tags against the queue
	always @(negedge clock) begin
		if (!rst) begin
			if (flush) flush_count++;
			if (free_valid[1] && !free_valid[0]) begin
				other_errors++;
				$display("error at time %0t: lane 1 freed a tag while lane 0 did not", $time);
			end
			for (int j = 0; j < SS_SIZE; j++) begin
				if (free_valid[j] && expect_q.size() == 0) begin
					other_errors++;
					$display("error at time %0t: tag %0d freed with nothing left to retire",
						$time, free_tag[j]);
				end else if (free_valid[j]) begin
					check_tag(free_tag[j], expect_q.pop_front(), $sformatf("free_tag[%0d]", j));
					check_idx(free_wr_idx[j], idx_q.pop_front(),
						$sformatf("free_wr_idx[%0d]", j));
				end
			end
		end
	end

	task automatic test_reset_state();
		$display("test: reset state");
		check_count(free_rows, (ROB_IDX_W+1)'(ROB_SIZE), "free_rows");
		check_bit(full, 1'b0, "full");
		check_bit(free_valid[0], 1'b0, "free_valid[0]");
		check_bit(free_valid[1], 1'b0, "free_valid[1]");
		check_bit(flush, 1'b0, "flush");
		check_bit(halted, 1'b0, "halted");
	endtask

	task automatic test_single_alu();
		$display("test: single ALU op");
		issue_pair(1'b1, alu_word(), 1'b1, 1'b0, '0, 1'b0);
		for (int n = 1; n <= 5; n++) begin
			step();
			check_bit(free_valid[0], logic'(n == 5), "free_valid[0]");   // EXEC_LAT + 2
		end
		drain(20);
	endtask

	task automatic test_stream();
		$display("test: paired stream");
		for (int k = 0; k < 6; k++) begin
			issue_pair(1'b1, alu_word(), 1'b1, 1'b1, alu_word(), 1'b1);
			if (k % 2 == 1) step();
		end
		drain(60);
	endtask

	task automatic test_full_rob();
		$display("test: full ROB");
		full_seen = 1'b0;
		repeat (5) issue_pair(1'b1, alu_word(), 1'b1, 1'b1, alu_word(), 1'b1);
		check_bit(full_seen, 1'b1, "full");
		drain(60);
	endtask

	task automatic test_branches();
		logic [31:0] br_npc;
		int          br_disp;
		int          fc0;
		$display("test: branches");
		br_disp = -6;
		br_npc  = pc_base + 32'd4;
		issue_pair(1'b1, br_word(BR_ALWAYS, br_disp), 1'b1, 1'b1, alu_word(), 1'b0);
		issue_pair(1'b1, alu_word(), 1'b0, 1'b1, alu_word(), 1'b0);   // Younger ops get flushed
		for (int n = 0; n < 20 && !flush; n++) step();
		if (!flush) begin
			other_errors++;
			$display("error at time %0t: no flush after the mispredicted branch", $time);
		end else begin
			check_pc(redirect_pc, br_npc + 32'(4 * br_disp), "redirect_pc");
			step();
			check_bit(flush, 1'b0, "flush");
			check_count(free_rows, (ROB_IDX_W+1)'(ROB_SIZE), "free_rows");
		end
		drain(20);
		fc0 = flush_count;
		issue_pair(1'b1, br_word(BR_NEVER, 40), 1'b1, 1'b1, alu_word(), 1'b1);
		drain(40);
		check_bit(logic'(flush_count != fc0), 1'b0, "flush");
	endtask

	task automatic test_halt();
		instr_u halt_w;
		halt_w = '0;
		halt_w.alu.opcode = OP_HALT;
		$display("test: halt");
		issue_pair(1'b1, alu_word(), 1'b1, 1'b1, alu_word(), 1'b1);
		issue_pair(1'b1, halt_w, 1'b1, 1'b1, alu_word(), 1'b0);
		issue_pair(1'b1, alu_word(), 1'b0, 1'b1, alu_word(), 1'b0);
		repeat (20) step();
		check_bit(halted, 1'b1, "halted");
		if (expect_q.size() != 0) begin
			other_errors++;
			$display("error at time %0t: rows before the halt never retired", $time);
		end
		repeat (10) step();
		check_bit(halted, 1'b1, "halted");   // Sticky
		apply_reset();
		check_bit(halted, 1'b0, "halted");
	endtask

	initial begin
		void'($urandom(15));
		clock = 1'b0;
		rst   = 1'b1;
		for (int j = 0; j < SS_SIZE; j++) begin
			inst_valid[j] = 1'b0;
			inst_word[j]  = '0;
			npc[j]        = '0;
			t_new_in[j]   = '0;
			t_old_in[j]   = '0;
		end
		mismatches   = 0;
		other_errors = 0;
		flush_count  = 0;
		tag_ctr      = 1;
		pc_base      = 32'h1000;
		full_seen    = 1'b0;
		apply_reset();
		test_reset_state();
		test_single_alu();
		test_stream();
		test_full_rob();
		test_branches();
		test_halt();
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Six tests at 200 cycles each
	initial begin
		repeat (6 * 200) @(posedge clock);
		$display("watchdog: tests still running after %0d cycles", 6 * 200);
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* compile.f */
hw/ooo_pkg.sv
hw/dispatch_decode.sv
hw/exec_pipe.sv
hw/rob_tag_cam.sv
hw/rob.sv
hw/retire_unit.sv
hw/ooo_backend_top.sv
verif/ooo_backend_tb.sv

/* Makefile */
TOP := ooo_backend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
